/* Bender.yml */
package:
  name: cpu_core

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - common/bus_ctrl_if.sv
      - common/mem_if.sv
      - datapath/alu.sv
      - datapath/datapath.sv
      - logic/control_unit.sv
      - logic/apb_master.sv
      - logic/cpu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/cpu_sva.sv
      - bench/cpu_tb.sv

/* bench/cpu_sva.sv */
`timescale 1ns/1ps

module cpu_sva (
    input logic           clk,
    input logic           reset,
    input logic           psel,
    input logic           penable,
    input logic           pwrite,
    input logic           pready,
    input cpu_pkg::word_t paddr,
    input cpu_pkg::word_t pwdata,
    input logic           halted
);

    int fail_count;  // Assertion failures so far.

    initial
        fail_count = 0;

    // Access phase only after a setup cycle.
    enable_after_setup: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> $past(psel && !penable))
        else
        begin
            fail_count = fail_count + 1;
            $error("penable rose without a setup cycle");
        end

    setup_then_access: assert property (@(posedge clk) disable iff (reset)
        (psel && !penable) |=> (psel && penable))
        else
        begin
            fail_count = fail_count + 1;
            $error("setup cycle not followed by access");
        end

    // Held through wait states.
    stable_in_wait: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pready) |=> (psel && penable && $stable(paddr) && $stable(pwrite)))
        else
        begin
            fail_count = fail_count + 1;
            $error("APB address or direction changed during a wait state");
        end

    stable_wdata: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pready && pwrite) |=> $stable(pwdata))
        else
        begin
            fail_count = fail_count + 1;
            $error("pwdata changed during a write wait state");
        end

    no_transfer_halted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !psel)
        else
        begin
            fail_count = fail_count + 1;
            $error("APB transfer while halted");
        end

endmodule

bind cpu_top cpu_sva u_sva (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pready  (pready),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .halted  (halted)
);

/* bench/cpu_tb.sv */
`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int prog_len    = 18;
    localparam int cycle_limit = 40 * prog_len;
    localparam int quiet_len   = 100;  // Cycles watched after halt.

    logic  clk;
    logic  reset;
    word_t prdata;
    logic  pready;
    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t paddr;
    word_t pwdata;
    logic  halted;

    word_t  mem [64];
    int     tag [64];     // Test that each instruction belongs to.
    logic   exp_write [$];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    int     exp_tag [$];
    int     errors [1:6];
    int     checks [1:6];
    integer seed;
    int     waits_left;
    int     wait_cycles;
    int     cycle_count;
    int     total_errors;
    int     total_checks;
    int     assert_fails;

    cpu_top uut (
        .clk     (clk),
        .reset   (reset),
        .prdata  (prdata),
        .pready  (pready),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .halted  (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void put_instr(int addr, opcode_t op, reg_idx_t ra, reg_idx_t rb,
                                      reg_idx_t rc, logic [14:0] field, int test);
        mem[addr] = {op, ra, rb, rc, field};
        tag[addr] = test;
    endfunction

    function automatic void load_program();
        for (int i = 0; i < 64; i++)
        begin
            mem[i] = word_t'(i) ^ 32'hA5A5_0000;
            tag[i] = 4;
        end
        put_instr(0, `OP_LD, 1, 0, 0, 15'h20, 2);
        put_instr(1, `OP_LD, 2, 0, 0, 15'h21, 2);
        put_instr(2, `OP_LD, 3, 0, 0, 15'h22, 2);
        put_instr(3, `OP_OR, 4, 1, 2, 15'h0, 2);
        put_instr(4, `OP_ST, 4, 0, 0, 15'h30, 2);   // Expected 0x16.
        put_instr(5, `OP_ADD, 5, 2, 3, 15'h0, 3);
        put_instr(6, `OP_ST, 5, 0, 0, 15'h31, 3);
        put_instr(7, `OP_SUB, 6, 1, 3, 15'h0, 3);   // Wraps below zero.
        put_instr(8, `OP_ST, 6, 0, 0, 15'h32, 3);
        put_instr(9, `OP_AND, 7, 1, 3, 15'h0, 3);
        put_instr(10, `OP_ST, 7, 0, 0, 15'h33, 3);
        put_instr(11, `OP_SHL, 8, 3, 1, 15'h0, 3);
        put_instr(12, `OP_ST, 8, 0, 0, 15'h34, 3);
        put_instr(13, `OP_LD, 11, 0, 0, 15'h23, 4);
        put_instr(14, `OP_ST, 11, 0, 0, 15'h35, 4);  // Store right after the load.
        put_instr(15, `OP_SHR, 10, 11, 1, 15'h0, 3);
        put_instr(16, `OP_ST, 10, 0, 0, 15'h36, 3);
        put_instr(17, `OP_HALT, 0, 0, 0, 15'h0, 6);
        mem[32'h20] = 32'h12;
        mem[32'h21] = 32'h14;
        mem[32'h22] = 32'h18;
        mem[32'h23] = 32'hDEAD_BEEF;
    endfunction

    // Expected ALU result, ra = rb op rc.
    function automatic word_t alu_ref(opcode_t op, word_t b_val, word_t c_val);
        case (op)
            `OP_ADD: return b_val + c_val;
            `OP_SUB: return b_val - c_val;
            `OP_AND: return b_val & c_val;
            `OP_OR:  return b_val | c_val;
            `OP_SHR: return b_val >> c_val[4:0];
            `OP_SHL: return b_val << c_val[4:0];
            default: return '0;
        endcase
    endfunction

    function automatic void queue_transfer(logic write, word_t addr, word_t data, int test);
        exp_write.push_back(write);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_tag.push_back(test);
    endfunction

    // Runs the program on a register array and queues every APB transfer in order.
    function automatic void build_expected();
        word_t   regs [16];
        word_t   img [64];
        word_t   ir;
        opcode_t op;
        int      ra;
        int      maddr;
        bit      running;
        img = mem;
        foreach (regs[i])
            regs[i] = '0;
        running = 1'b1;
        for (int pc = 0; pc < 64 && running; pc++)
        begin
            ir    = img[pc];
            op    = ir[`OP_HI:`OP_LO];
            ra    = ir[`RA_HI:`RA_LO];
            maddr = ir[5:0];  // Memory holds 64 words.
            queue_transfer(1'b0, pc, ir, (pc == 0) ? 1 : 4);
            case (op)
                `OP_LD:
                begin
                    queue_transfer(1'b0, ir[14:0], img[maddr], tag[pc]);
                    regs[ra] = img[maddr];
                end
                `OP_ST:
                begin
                    queue_transfer(1'b1, ir[14:0], regs[ra], tag[pc]);
                    img[maddr] = regs[ra];
                end
                `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHR, `OP_SHL:
                    regs[ra] = alu_ref(op, regs[ir[`RB_HI:`RB_LO]], regs[ir[`RC_HI:`RC_LO]]);
                `OP_HALT: running = 1'b0;
                default: ;
            endcase
        end
    endfunction

    task automatic check_transfer();
        logic  e_write;
        word_t e_addr;
        word_t e_data;
        int    t;
        int    bad;
        if (exp_addr.size() == 0)
        begin
            $display("Unexpected APB transfer at %0t to address %h after the program.",
                     $time, paddr);
            errors[6]++;
            return;
        end
        e_write = exp_write.pop_front();
        e_addr  = exp_addr.pop_front();
        e_data  = exp_data.pop_front();
        t       = exp_tag.pop_front();
        bad     = 0;
        checks[t]++;
        if (pwrite !== e_write)
        begin
            $display("[FAIL] t=%0t pwrite: expected %b, got %b", $time, e_write, pwrite);
            bad++;
        end
        if (paddr !== e_addr)
        begin
            $display("[FAIL] t=%0t paddr: expected %h, got %h", $time, e_addr, paddr);
            bad++;
        end
        if (e_write && pwdata !== e_data)
        begin
            $display("[FAIL] t=%0t pwdata: expected %h, got %h", $time, e_data, pwdata);
            bad++;
        end
        if (e_write && e_addr == 32'h30 && pwdata !== 32'h16)
        begin
            $display("[FAIL] t=%0t pwdata: expected %h, got %h", $time, 32'h16, pwdata);
            bad++;
        end
        errors[t] += bad;
        if (e_write)
        begin
            checks[5]++;
            errors[5] += bad;  // Store values and order under wait states.
        end
    endtask

    task automatic report_test(int t, string name);
        $display("Test %0d %s: %0d checks, %0d errors, %s", t, name, checks[t], errors[t],
                 (errors[t] == 0) ? "PASS" : "FAIL");
    endtask

    // APB memory with 0 to 3 wait cycles per access.
    always @(negedge clk)
    begin
        pready = 1'b0;
        if (!reset && psel && !penable)
            waits_left = $unsigned($random(seed)) % 4;
        else if (!reset && psel && penable)
        begin
            if (waits_left == 0)
            begin
                pready = 1'b1;
                if (pwrite)
                    mem[paddr[5:0]] = pwdata;
                else
                    prdata = mem[paddr[5:0]];
            end
            else
            begin
                waits_left  = waits_left - 1;
                wait_cycles = wait_cycles + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        if (!reset && psel && penable && pready)
            check_transfer();
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the program did not finish.", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        reset        = 1'b1;
        prdata       = '0;
        pready       = 1'b0;
        seed         = 90085;
        waits_left   = 0;
        wait_cycles  = 0;
        cycle_count  = 0;
        total_errors = 0;
        total_checks = 0;
        assert_fails = 0;
        foreach (errors[t])
        begin
            errors[t] = 0;
            checks[t] = 0;
        end
        load_program();
        build_expected();
        repeat (4)
        begin
            @(negedge clk);
            checks[1]++;
            if (psel !== 1'b0)
            begin
                $display("[FAIL] t=%0t psel: expected 0, got %b", $time, psel);
                errors[1]++;
            end
        end
        reset = 1'b0;
        wait (checks[1] > 4);  // First fetch seen.
        report_test(1, "reset and first fetch");
        wait (halted === 1'b1);
        if (exp_addr.size() != 0)
        begin
            $display("%0d expected APB transfers never appeared before halt.", exp_addr.size());
            errors[4]++;
        end
        checks[5]++;
        if (wait_cycles == 0)
        begin
            $display("The memory inserted no wait states, so back-pressure was not exercised.");
            errors[5]++;
        end
        report_test(2, "or of loaded words");
        report_test(3, "alu operations");
        report_test(4, "store after load and fetch order");
        report_test(5, "wait states");
        repeat (quiet_len)
        begin
            @(negedge clk);
            checks[6]++;
            if (psel !== 1'b0)
            begin
                $display("[FAIL] t=%0t psel: expected 0, got %b", $time, psel);
                errors[6]++;
            end
            if (halted !== 1'b1)
            begin
                $display("[FAIL] t=%0t halted: expected 1, got %b", $time, halted);
                errors[6]++;
            end
        end
        report_test(6, "halt");
        for (int t = 1; t <= 6; t++)
        begin
            total_errors += errors[t];
            total_checks += checks[t];
        end
        assert_fails = uut.u_sva.fail_count;
        total_errors += assert_fails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", total_checks,
                 total_errors, assert_fails);
        if (total_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* common/bus_ctrl_if.sv */
`timescale 1ns/1ps

interface bus_ctrl_if;
    import cpu_pkg::*;

    // Bus sources, only one high per cycle.
    logic     pc_out, mdr_out, zlow_out, reg_out, addr_out;
    reg_idx_t reg_sel;
    // Destinations, loaded on the rising edge.
    logic     pc_in, ir_in, mar_in, mdr_in_bus, y_in, z_in, reg_in;
    reg_idx_t reg_dst;
    alu_op_t  alu_op;
    word_t    ir;  // Instruction register, back to the decoder.

    modport seq (
        output pc_out, mdr_out, zlow_out, reg_out, addr_out, reg_sel,
        output pc_in, ir_in, mar_in, mdr_in_bus, y_in, z_in, reg_in, reg_dst,
        output alu_op,
        input  ir
    );

    modport dp (
        input  pc_out, mdr_out, zlow_out, reg_out, addr_out, reg_sel,
        input  pc_in, ir_in, mar_in, mdr_in_bus, y_in, z_in, reg_in, reg_dst,
        input  alu_op,
        output ir
    );

endinterface

/* common/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and register file sizes.
`define WORD_W       32
`define REG_NUM      16
`define REG_IDX_W    4
`define OP_W         5
`define ADDR_FIELD_W 15

// Opcodes as they appear in IR[31:27].
`define OP_LD   5'd0
`define OP_ST   5'd2
`define OP_ADD  5'd3
`define OP_SUB  5'd4
`define OP_AND  5'd5
`define OP_OR   5'd6
`define OP_SHR  5'd7
`define OP_SHL  5'd8
`define OP_HALT 5'd27

// Instruction word fields.
`define OP_HI 31
`define OP_LO 27
`define RA_HI 26
`define RA_LO 23
`define RB_HI 22
`define RB_LO 19
`define RC_HI 18
`define RC_LO 15

`endif

/* common/cpu_pkg.sv */
package cpu_pkg;

    `include "cpu_consts.svh"

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`OP_W-1:0]      opcode_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`OP_W-1:0]      alu_op_t;  // Opcode values plus the increment below.

    // Increment of the bus value, used for PC + 1 during fetch.
    localparam alu_op_t ALU_INC = 5'd31;

    // Sequencer steps. The *_WAIT steps hold a memory request until done.
    typedef enum logic [3:0] {
        RESET_S, T0, T1, T1_WAIT, T2, T3, T4, T4_WAIT, T5, T5_WAIT, HALTED
    } step_t;

endpackage

/* common/mem_if.sv */
`timescale 1ns/1ps

interface mem_if;
    import cpu_pkg::*;

    logic  req;    // Held until done.
    logic  write;
    word_t addr;   // From MAR.
    word_t wdata;  // From MDR.
    word_t rdata;
    logic  done;   // One cycle, at the end of the transfer.

    modport seq  (output req, write, input done);
    modport dp   (output addr, wdata, input rdata, done, write);
    modport port (input req, write, addr, wdata, output rdata, done);

endinterface

/* datapath/alu.sv */
`timescale 1ns/1ps

`include "cpu_consts.svh"

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,       // Y register.
    input  cpu_pkg::word_t   b,       // Bus value.
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    always_comb
    begin
        case (op)
            `OP_ADD: result = a + b;
            `OP_SUB: result = a - b;
            `OP_AND: result = a & b;
            `OP_OR:  result = a | b;
            `OP_SHR: result = a >> b[4:0];  // Shift count from the low bits.
            `OP_SHL: result = a << b[4:0];
            ALU_INC: result = b + 1'b1;
            default: result = b;
        endcase
    end

endmodule

/* datapath/datapath.sv */
`timescale 1ns/1ps

`include "cpu_consts.svh"

module datapath (
    input  logic   clk,
    input  logic   reset,
    bus_ctrl_if.dp ctrl,
    mem_if.dp      mem
);
    import cpu_pkg::*;

    word_t bus;
    word_t pc;
    word_t ir;
    word_t mar;
    word_t mdr;
    word_t y;
    word_t z;
    word_t alu_result;
    word_t regs [`REG_NUM];

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (y),
        .b      (bus),
        .result (alu_result)
    );

    // Single shared bus. The sequencer enables at most one source.
    always_comb
    begin
        if (ctrl.pc_out)
            bus = pc;
        else if (ctrl.mdr_out)
            bus = mdr;
        else if (ctrl.zlow_out)
            bus = z;
        else if (ctrl.reg_out)
            bus = regs[ctrl.reg_sel];
        else if (ctrl.addr_out)
            bus = word_t'(ir[`ADDR_FIELD_W-1:0]);  // Zero-extended address field.
        else
            bus = '0;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= '0;
        else if (ctrl.pc_in)
            pc <= bus;
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.ir_in)
            ir <= bus;
        if (ctrl.mar_in)
            mar <= bus;
        // Read data arrives on the done cycle of a read.
        if (mem.done && !mem.write)
            mdr <= mem.rdata;
        else if (ctrl.mdr_in_bus)
            mdr <= bus;
        if (ctrl.y_in)
            y <= bus;
        if (ctrl.z_in)
            z <= alu_result;
        if (ctrl.reg_in)
            regs[ctrl.reg_dst] <= bus;
    end

    assign ctrl.ir   = ir;
    assign mem.addr  = mar;
    assign mem.wdata = mdr;

endmodule

/* logic/apb_master.sv */
`timescale 1ns/1ps

module apb_master (
    input  logic           clk,
    input  logic           reset,
    mem_if.port            mem,
    input  cpu_pkg::word_t prdata,
    input  logic           pready,
    output logic           psel,
    output logic           penable,
    output logic           pwrite,
    output cpu_pkg::word_t paddr,
    output cpu_pkg::word_t pwdata
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_t;

    apb_state_t state;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= IDLE;
            pwrite <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (mem.req)
                    begin
                        state  <= SETUP;
                        pwrite <= mem.write;
                    end
                end
                SETUP:   state <= ACCESS;
                ACCESS:  if (pready) state <= IDLE;  // Held through wait states.
                default: state <= IDLE;
            endcase
        end
    end

    // Address and data captured once per transfer, stable until the next.
    always_ff @(posedge clk)
    begin
        if (state == IDLE && mem.req)
        begin
            paddr  <= mem.addr;
            pwdata <= mem.wdata;
        end
    end

    assign psel      = (state != IDLE);
    assign penable   = (state == ACCESS);
    assign mem.done  = (state == ACCESS) && pready;
    assign mem.rdata = prdata;

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

`include "cpu_consts.svh"

module control_unit (
    input  logic    clk,
    input  logic    reset,
    bus_ctrl_if.seq ctrl,
    mem_if.seq      mem,
    output logic    halted
);
    import cpu_pkg::*;

    step_t    state;
    step_t    next_state;
    opcode_t  opcode;
    reg_idx_t ra;
    reg_idx_t rb;
    reg_idx_t rc;
    logic     is_alu;

    // Decode fields from IR.
    assign opcode = ctrl.ir[`OP_HI:`OP_LO];
    assign ra     = ctrl.ir[`RA_HI:`RA_LO];
    assign rb     = ctrl.ir[`RB_HI:`RB_LO];
    assign rc     = ctrl.ir[`RC_HI:`RC_LO];
    assign is_alu = (opcode == `OP_ADD) || (opcode == `OP_SUB) || (opcode == `OP_AND) ||
                    (opcode == `OP_OR)  || (opcode == `OP_SHR) || (opcode == `OP_SHL);

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= RESET_S;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            RESET_S: next_state = T0;
            T0:      next_state = T1;
            T1:      next_state = T1_WAIT;
            T1_WAIT: if (mem.done) next_state = T2;
            T2:      next_state = T3;
            T3:
            begin
                if (opcode == `OP_HALT)
                    next_state = HALTED;
                else if (is_alu || opcode == `OP_LD || opcode == `OP_ST)
                    next_state = T4;
                else
                    next_state = T0;  // Unknown opcode, skip.
            end
            T4:      next_state = (opcode == `OP_LD) ? T4_WAIT : T5;
            T4_WAIT: if (mem.done) next_state = T5;
            T5:      next_state = (opcode == `OP_ST) ? T5_WAIT : T0;
            T5_WAIT: if (mem.done) next_state = T0;
            HALTED:  next_state = HALTED;
            default: next_state = RESET_S;
        endcase
    end

    // Strobes for the current step.
    always_comb
    begin
        ctrl.pc_out = 1'b0; ctrl.mdr_out = 1'b0; ctrl.zlow_out = 1'b0;
        ctrl.reg_out = 1'b0; ctrl.addr_out = 1'b0;
        ctrl.pc_in = 1'b0; ctrl.ir_in = 1'b0; ctrl.mar_in = 1'b0; ctrl.mdr_in_bus = 1'b0;
        ctrl.y_in = 1'b0; ctrl.z_in = 1'b0; ctrl.reg_in = 1'b0;
        ctrl.reg_sel = ra;
        ctrl.reg_dst = ra;
        ctrl.alu_op  = ALU_INC;
        mem.req      = 1'b0;
        mem.write    = 1'b0;
        case (state)
            T0:  // PC to MAR, PC + 1 into Z.
            begin
                ctrl.pc_out = 1'b1; ctrl.mar_in = 1'b1; ctrl.z_in = 1'b1;
            end
            T1:
            begin
                ctrl.zlow_out = 1'b1; ctrl.pc_in = 1'b1; mem.req = 1'b1;
            end
            T1_WAIT: mem.req = 1'b1;
            T2:
            begin
                ctrl.mdr_out = 1'b1; ctrl.ir_in = 1'b1;
            end
            T3:
            begin
                if (is_alu)
                begin
                    ctrl.reg_out = 1'b1; ctrl.reg_sel = rb; ctrl.y_in = 1'b1;
                end
                else if (opcode == `OP_LD || opcode == `OP_ST)
                begin
                    ctrl.addr_out = 1'b1; ctrl.mar_in = 1'b1;
                end
            end
            T4:
            begin
                if (is_alu)
                begin
                    ctrl.reg_out = 1'b1; ctrl.reg_sel = rc;
                    ctrl.alu_op  = alu_op_t'(opcode); ctrl.z_in = 1'b1;
                end
                else if (opcode == `OP_ST)
                begin
                    ctrl.reg_out = 1'b1; ctrl.mdr_in_bus = 1'b1;  // ra into MDR.
                end
                else
                    mem.req = 1'b1;  // ld read.
            end
            T4_WAIT: mem.req = 1'b1;
            T5:
            begin
                if (opcode == `OP_ST)
                begin
                    mem.req = 1'b1; mem.write = 1'b1;
                end
                else if (is_alu)
                begin
                    ctrl.zlow_out = 1'b1; ctrl.reg_in = 1'b1;
                end
                else
                begin
                    ctrl.mdr_out = 1'b1; ctrl.reg_in = 1'b1;  // Loaded word into ra.
                end
            end
            T5_WAIT:
            begin
                mem.req = 1'b1; mem.write = 1'b1;
            end
            default: ;
        endcase
    end

    assign halted = (state == HALTED);

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::word_t prdata,
    input  logic           pready,
    output logic           psel,
    output logic           penable,
    output logic           pwrite,
    output cpu_pkg::word_t paddr,
    output cpu_pkg::word_t pwdata,
    output logic           halted
);
    import cpu_pkg::*;

    bus_ctrl_if ctrl_bus ();
    mem_if      mem_bus ();

    control_unit u_control (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl_bus.seq),
        .mem    (mem_bus.seq),
        .halted (halted)
    );

    datapath u_datapath (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.dp),
        .mem   (mem_bus.dp)
    );

    apb_master u_apb (
        .clk     (clk),
        .reset   (reset),
        .mem     (mem_bus.port),
        .prdata  (prdata),
        .pready  (pready),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata)
    );

endmodule

/* tb.f */
+incdir+common
common/cpu_pkg.sv
common/bus_ctrl_if.sv
common/mem_if.sv
datapath/alu.sv
datapath/datapath.sv
logic/control_unit.sv
logic/apb_master.sv
logic/cpu_top.sv
bench/cpu_sva.sv
bench/cpu_tb.sv
